//--- verilog/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// Native bus data width
`define SOC_WORD_W 32

////////////////////////////////////////////////////////////////////////////
// Reset sequencing
////////////////////////////////////////////////////////////////////////////

// Power-on counter, release when top bit sets (1024 cycles)
`define SOC_POR_CNT_W 11
// Core reset pulse length after a control write
`define SOC_CORE_RST_CYCLES 4

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////

// Control word, top of the CTRL region
`define SOC_CTRL_ADDR 32'hfffffffc
// Byte address widths of the two memories
`define SOC_BOOT_ADDR_W 14
`define SOC_MAIN_ADDR_W 12

// UART divider after reset, in clock cycles per bit
`define SOC_UART_DIV_RESET 16

`endif

//--- verilog/soc_pkg.sv
`default_nettype none

`include "soc_defs.svh"

package soc_pkg;

   // One native bus word
   typedef logic [`SOC_WORD_W-1:0] word_t;

   // Byte strobe, one bit per byte lane
   typedef logic [`SOC_WORD_W/8-1:0] strb_t;

   // Region code, address bits 31:30
   typedef enum logic [1:0] {
      REGION_MAIN = 2'd0,
      REGION_BOOT = 2'd1,
      REGION_UART = 2'd2,
      REGION_CTRL = 2'd3
   } region_t;

   // Word addresses, byte offset bits dropped
   typedef logic [`SOC_BOOT_ADDR_W-3:0] boot_waddr_t;
   typedef logic [`SOC_MAIN_ADDR_W-3:0] main_waddr_t;

endpackage

`default_nettype wire

//--- verilog/boot_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module boot_control (
   input  wire  clk,
   input  wire  reset,
   input  wire  ctrl_sel,
   output logic sys_resetn,
   output logic core_resetn,
   output logic mem_sel,
   output logic ctrl_ready
);

   // One extra slot for the idle position of the ring
   localparam int SEQ_W = `SOC_CORE_RST_CYCLES + 1;
   localparam logic [SEQ_W-1:0] SEQ_IDLE = SEQ_W'(1);

   logic [`SOC_POR_CNT_W-1:0] por_cnt;
   logic [SEQ_W-1:0]          rst_seq;

   ////////////////////////////////////////////////////////////////////////////
   // Power-on reset counter
   ////////////////////////////////////////////////////////////////////////////

   // Counts up until the top bit sets, then freezes
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         por_cnt <= '0;
      end else if (!por_cnt[`SOC_POR_CNT_W-1]) begin
         por_cnt <= por_cnt + 1'b1;
      end
   end

   assign sys_resetn = por_cnt[`SOC_POR_CNT_W-1];

   ////////////////////////////////////////////////////////////////////////////
   // Soft reset sequencer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrl_ready <= 1'b0;
         mem_sel    <= 1'b0;
         rst_seq    <= SEQ_IDLE;
      end else if (!sys_resetn) begin
         // Held while the power-on count runs
         ctrl_ready <= 1'b0;
         mem_sel    <= 1'b0;
         rst_seq    <= SEQ_IDLE;
      end else begin
         // Ack one cycle after the select
         ctrl_ready <= ctrl_sel;
         // Fetch moves to main memory, sticky until reset
         if (ctrl_sel) begin
            mem_sel <= 1'b1;
         end
         // Kick off on the ack, then rotate back to idle
         if (ctrl_ready || !rst_seq[0]) begin
            rst_seq <= {rst_seq[SEQ_W-2:0], rst_seq[SEQ_W-1]};
         end
      end
   end

   // Core held low outside the idle slot
   assign core_resetn = sys_resetn && rst_seq[0];

   // No core pulse before the hand-over to main memory
   a_no_early_core_reset : assert property (@(posedge clk) disable iff (reset)
      (sys_resetn && !mem_sel) |-> core_resetn);

   // Ack is a lone pulse, no new select on top of it
   a_no_sel_in_ack : assert property (@(posedge clk) disable iff (reset)
      ctrl_ready |-> !ctrl_sel);

endmodule

`default_nettype wire

//--- verilog/native_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module native_interconnect (
   input  wire                 clk,
   input  wire                 reset,
   input  soc_pkg::word_t      daddr,
   input  wire                 valid,
   input  wire                 mem_sel,
   output logic                ready,
   output soc_pkg::word_t      rdata,
   output soc_pkg::word_t      rinstr,
   // Slave selects
   output logic                main_sel,
   output logic                boot_sel,
   output logic                uart_sel,
   output logic                ctrl_sel,
   // Slave responses
   input  wire                 main_ready,
   input  wire                 boot_ready,
   input  wire                 uart_ready,
   input  wire                 ctrl_ready,
   input  soc_pkg::word_t      main_rdata,
   input  soc_pkg::word_t      boot_rdata,
   input  soc_pkg::word_t      uart_rdata,
   input  soc_pkg::word_t      main_rinstr,
   input  soc_pkg::word_t      boot_rinstr
);

   soc_pkg::region_t region;
   soc_pkg::region_t resp_region;
   logic             req;

   // Top two address bits pick the slave
   assign region = soc_pkg::region_t'(daddr[`SOC_WORD_W-1:`SOC_WORD_W-2]);

   // Valid stays up through the ack cycle, so mask it there
   assign req = valid && !ready;

   assign main_sel = req && (region == soc_pkg::REGION_MAIN);
   assign boot_sel = req && (region == soc_pkg::REGION_BOOT);
   assign uart_sel = req && (region == soc_pkg::REGION_UART);
   assign ctrl_sel = req && (region == soc_pkg::REGION_CTRL);

   // Remember who was addressed, for the response cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         resp_region <= soc_pkg::REGION_MAIN;
      end else if (req) begin
         resp_region <= region;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response mux
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (resp_region)
         soc_pkg::REGION_MAIN: begin
            ready = main_ready;
            rdata = main_rdata;
         end
         soc_pkg::REGION_BOOT: begin
            ready = boot_ready;
            rdata = boot_rdata;
         end
         soc_pkg::REGION_UART: begin
            ready = uart_ready;
            rdata = uart_rdata;
         end
         default: begin
            // Control word reads back the fetch select
            ready = ctrl_ready;
            rdata = {{(`SOC_WORD_W-1){1'b0}}, mem_sel};
         end
      endcase
   end

   // Boot memory until the hand-over
   assign rinstr = mem_sel ? main_rinstr : boot_rinstr;

   // Single-cycle ack, never back to back
   a_ready_single : assert property (@(posedge clk) disable iff (reset)
      ready |=> !ready);

endmodule

`default_nettype wire

//--- verilog/native_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module native_memory #(
   parameter type addr_t = soc_pkg::main_waddr_t
) (
   input  wire            clk,
   input  wire            reset,
   input  wire            sel,
   input  addr_t          iaddr,
   input  addr_t          daddr,
   input  soc_pkg::word_t wdata,
   input  soc_pkg::strb_t wstrb,
   output soc_pkg::word_t rdata,
   output soc_pkg::word_t rinstr,
   output logic           mem_ready
);

   localparam int DEPTH = 1 << $bits(addr_t);
   localparam int LANES = `SOC_WORD_W / 8;

   soc_pkg::word_t mem [0:DEPTH-1];
   soc_pkg::strb_t we;

   // Lane enables, only for a selected access
   assign we = sel ? wstrb : '0;

   ////////////////////////////////////////////////////////////////////////////
   // Data port, byte writes and registered read
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      for (int i = 0; i < LANES; i++) begin
         if (we[i]) begin
            mem[daddr][8*i +: 8] <= wdata[8*i +: 8];
         end
      end
      // Old contents on a same-cycle write
      rdata <= mem[daddr];
   end

   // Instruction port reads every cycle
   always_ff @(posedge clk) begin
      rinstr <= mem[iaddr];
   end

   // Fixed one-cycle ack
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mem_ready <= 1'b0;
      end else begin
         mem_ready <= sel;
      end
   end

   // Writes only on the first cycle of a selected access, never in the ack cycle
   a_write_needs_sel : assert property (@(posedge clk) disable iff (reset)
      (|we) |-> (sel && !mem_ready));

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module uart_tx (
   input  wire            clk,
   input  wire            reset,
   input  wire            sel,
   input  wire            reg_addr,
   input  soc_pkg::word_t wdata,
   input  soc_pkg::strb_t wstrb,
   output soc_pkg::word_t rdata,
   output logic           uart_ready,
   output logic           ser_tx
);

   localparam int LANES = `SOC_WORD_W / 8;

   soc_pkg::word_t div;
   soc_pkg::word_t bit_cnt;
   logic [3:0]     bit_idx;
   logic [9:0]     shift;
   logic           busy;

   ////////////////////////////////////////////////////////////////////////////
   // Registers and bit timing
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         div        <= `SOC_WORD_W'(`SOC_UART_DIV_RESET);
         bit_cnt    <= '0;
         bit_idx    <= '0;
         shift      <= '1;
         busy       <= 1'b0;
         uart_ready <= 1'b0;
         ser_tx     <= 1'b1;
      end else begin
         uart_ready <= sel;
         // Line driven from a register, one cycle behind the shifter
         ser_tx     <= busy ? shift[0] : 1'b1;
         // Divider at offset 0, byte writable
         if (sel && !reg_addr) begin
            for (int i = 0; i < LANES; i++) begin
               if (wstrb[i]) begin
                  div[8*i +: 8] <= wdata[8*i +: 8];
               end
            end
         end
         if (busy) begin
            // End of bit period
            if ((bit_cnt + 1'b1) >= div) begin
               bit_cnt <= '0;
               shift   <= {1'b1, shift[9:1]};
               bit_idx <= bit_idx + 1'b1;
               // Stop bit done
               if (bit_idx == 4'd9) begin
                  busy <= 1'b0;
               end
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end else if (sel && reg_addr && wstrb[0]) begin
            // Stop, data LSB first, start
            shift   <= {1'b1, wdata[7:0], 1'b0};
            bit_cnt <= '0;
            bit_idx <= '0;
            busy    <= 1'b1;
         end
      end
   end

   // Read data, busy flag at offset 4
   always_ff @(posedge clk) begin
      if (sel) begin
         rdata <= reg_addr ? {{(`SOC_WORD_W-1){1'b0}}, busy} : div;
      end
   end

   // Idle line
   a_idle_high : assert property (@(posedge clk) disable iff (reset)
      !busy |-> ser_tx);

endmodule

`default_nettype wire

//--- verilog/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module soc_top (
   input  wire            clk,
   input  wire            reset,
   // Core master port
   input  soc_pkg::word_t iaddr,
   input  soc_pkg::word_t daddr,
   input  soc_pkg::word_t wdata,
   input  soc_pkg::strb_t wstrb,
   input  wire            valid,
   output logic           ready,
   output soc_pkg::word_t rdata,
   output soc_pkg::word_t rinstr,
   output logic           ser_tx,
   output logic           sys_resetn,
   output logic           core_resetn,
   output logic           mem_sel
);

   // Everything but the controller waits for the power-on release
   logic           blk_reset;

   // Slave selects from the interconnect
   logic           main_sel;
   logic           boot_sel;
   logic           uart_sel;
   logic           ctrl_sel;

   // Slave responses back to the interconnect
   logic           main_ready;
   logic           boot_ready;
   logic           uart_ready;
   logic           ctrl_ready;
   soc_pkg::word_t main_rdata;
   soc_pkg::word_t boot_rdata;
   soc_pkg::word_t uart_rdata;
   soc_pkg::word_t main_rinstr;
   soc_pkg::word_t boot_rinstr;

   assign blk_reset = !sys_resetn;

   ////////////////////////////////////////////////////////////////////////////
   // Reset and fetch control
   ////////////////////////////////////////////////////////////////////////////

   boot_control u_boot_control (
      .clk         (clk),
      .reset       (reset),
      .ctrl_sel    (ctrl_sel),
      .sys_resetn  (sys_resetn),
      .core_resetn (core_resetn),
      .mem_sel     (mem_sel),
      .ctrl_ready  (ctrl_ready)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Interconnect
   ////////////////////////////////////////////////////////////////////////////

   native_interconnect u_interconnect (
      .clk         (clk),
      .reset       (blk_reset),
      .daddr       (daddr),
      .valid       (valid),
      .mem_sel     (mem_sel),
      .ready       (ready),
      .rdata       (rdata),
      .rinstr      (rinstr),
      .main_sel    (main_sel),
      .boot_sel    (boot_sel),
      .uart_sel    (uart_sel),
      .ctrl_sel    (ctrl_sel),
      .main_ready  (main_ready),
      .boot_ready  (boot_ready),
      .uart_ready  (uart_ready),
      .ctrl_ready  (ctrl_ready),
      .main_rdata  (main_rdata),
      .boot_rdata  (boot_rdata),
      .uart_rdata  (uart_rdata),
      .main_rinstr (main_rinstr),
      .boot_rinstr (boot_rinstr)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Slaves
   ////////////////////////////////////////////////////////////////////////////

   // Word index from the byte address
   native_memory #(
      .addr_t (soc_pkg::boot_waddr_t)
   ) u_boot_mem (
      .clk       (clk),
      .reset     (blk_reset),
      .sel       (boot_sel),
      .iaddr     (iaddr[`SOC_BOOT_ADDR_W-1:2]),
      .daddr     (daddr[`SOC_BOOT_ADDR_W-1:2]),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (boot_rdata),
      .rinstr    (boot_rinstr),
      .mem_ready (boot_ready)
   );

   native_memory #(
      .addr_t (soc_pkg::main_waddr_t)
   ) u_main_mem (
      .clk       (clk),
      .reset     (blk_reset),
      .sel       (main_sel),
      .iaddr     (iaddr[`SOC_MAIN_ADDR_W-1:2]),
      .daddr     (daddr[`SOC_MAIN_ADDR_W-1:2]),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (main_rdata),
      .rinstr    (main_rinstr),
      .mem_ready (main_ready)
   );

   // Offset 4 picks the data register
   uart_tx u_uart (
      .clk        (clk),
      .reset      (blk_reset),
      .sel        (uart_sel),
      .reg_addr   (daddr[2]),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .rdata      (uart_rdata),
      .uart_ready (uart_ready),
      .ser_tx     (ser_tx)
   );

endmodule

`default_nettype wire

//--- verif/soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module soc_tb;

   logic           clk;
   logic           reset;
   soc_pkg::word_t iaddr;
   soc_pkg::word_t daddr;
   soc_pkg::word_t wdata;
   soc_pkg::strb_t wstrb;
   logic           valid;
   wire            ready;
   soc_pkg::word_t rdata;
   soc_pkg::word_t rinstr;
   wire            ser_tx;
   wire            sys_resetn;
   wire            core_resetn;
   wire            mem_sel;

   // Main memory reference, one entry per word
   soc_pkg::word_t main_model [0:1023];

   soc_top u_dut (
      .clk         (clk),
      .reset       (reset),
      .iaddr       (iaddr),
      .daddr       (daddr),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .valid       (valid),
      .ready       (ready),
      .rdata       (rdata),
      .rinstr      (rinstr),
      .ser_tx      (ser_tx),
      .sys_resetn  (sys_resetn),
      .core_resetn (core_resetn),
      .mem_sel     (mem_sel)
   );

   // 40 ns period
   always #20 clk = ~clk;

   task automatic halt_on_error();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input soc_pkg::word_t got,
                              input soc_pkg::word_t exp);
      assert (got === exp) else begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         halt_on_error();
      end
   endtask

   // Write lands only in the strobed byte lanes
   function automatic soc_pkg::word_t merge_bytes(input soc_pkg::word_t old_w,
                                                  input soc_pkg::word_t new_w,
                                                  input soc_pkg::strb_t strb);
      soc_pkg::word_t res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Master side of the native bus
   ////////////////////////////////////////////////////////////////////////////

   // One access, ack expected one cycle after valid
   task automatic bus_access(input soc_pkg::word_t addr, input soc_pkg::word_t data,
                             input soc_pkg::strb_t strb, output soc_pkg::word_t rd,
                             output soc_pkg::word_t ri);
      int waited;
      waited = 0;
      @(negedge clk);
      daddr = addr;
      wdata = data;
      wstrb = strb;
      valid = 1'b1;
      do begin
         @(negedge clk);
         waited++;
         if (waited > 20) begin
            $display("Timeout waiting for ready at address %h", addr);
            halt_on_error();
         end
      end while (ready !== 1'b1);
      check_value("ready_latency", soc_pkg::word_t'(waited), 32'd1);
      rd = rdata;
      ri = rinstr;
      // Dropped in the ready cycle, the ack masks it anyway
      valid = 1'b0;
      wstrb = '0;
   endtask

   // Cycles until core_resetn reaches the given level
   task automatic core_reset_cycles(input logic level, output int n);
      n = 0;
      while (core_resetn !== level) begin
         @(negedge clk);
         n++;
         if (n > 50) begin
            $display("Timeout waiting for core_resetn to change");
            halt_on_error();
         end
      end
   endtask

   // Mid-bit sampling of one frame, divider in clock cycles
   task automatic decode_frame(input logic [7:0] exp, input int d);
      int         waited;
      logic [7:0] got;
      waited = 0;
      while (ser_tx !== 1'b0) begin
         @(negedge clk);
         waited++;
         if (waited > 8) begin
            $display("Timeout waiting for the UART start bit");
            halt_on_error();
         end
      end
      repeat (d / 2) @(negedge clk);
      check_value("ser_tx_start", soc_pkg::word_t'(ser_tx), 32'd0);
      for (int k = 0; k < 8; k++) begin
         repeat (d) @(negedge clk);
         got[k] = ser_tx;
      end
      check_value("ser_tx_data", {24'h0, got}, {24'h0, exp});
      repeat (d) @(negedge clk);
      check_value("ser_tx_stop", soc_pkg::word_t'(ser_tx), 32'd1);
   endtask

   // Everything held while the power-on count runs
   a_por_hold : assert property (@(posedge clk) disable iff (reset)
      !sys_resetn |-> (!core_resetn && !ready && !mem_sel))
      else begin
         $display("[FAIL] core_resetn %h ready %h mem_sel %h in power-on hold",
                  core_resetn, ready, mem_sel);
         halt_on_error();
      end

   // Single-cycle ack
   a_ready_pulse : assert property (@(posedge clk) disable iff (reset)
      ready |=> !ready)
      else begin
         $display("[FAIL] ready %h high in two consecutive cycles", ready);
         halt_on_error();
      end

   initial begin
      int             n;
      int             idx;
      int             d;
      int             slots [6];
      soc_pkg::word_t rd;
      soc_pkg::word_t ri;
      soc_pkg::word_t w;
      soc_pkg::strb_t s;
      logic [7:0]     tx_byte;
      void'($urandom(32'h4f7e));
      clk   = 1'b0;
      reset = 1'b1;
      iaddr = '0;
      daddr = '0;
      wdata = '0;
      wstrb = '0;
      valid = 1'b0;
      repeat (8) @(negedge clk);
      reset = 1'b0;

      // Power-on release after 1024 cycles
      n = 0;
      while (sys_resetn !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > 2000) begin
            $display("Timeout waiting for sys_resetn to rise");
            halt_on_error();
         end
      end
      check_value("sys_resetn_cycles", soc_pkg::word_t'(n), 32'd1024);

      ////////////////////////////////////////////////////////////////////////////
      // Main memory, full words then strobed merges
      ////////////////////////////////////////////////////////////////////////////

      for (int i = 0; i < 6; i++) begin
         slots[i] = int'($urandom % 1024);
         w = $urandom;
         bus_access(soc_pkg::word_t'(slots[i] << 2), w, 4'hf, rd, ri);
         main_model[slots[i]] = w;
      end
      for (int i = 0; i < 12; i++) begin
         idx = slots[$urandom % 6];
         s = 4'($urandom % 15 + 1);
         w = $urandom;
         bus_access(soc_pkg::word_t'(idx << 2), w, s, rd, ri);
         main_model[idx] = merge_bytes(main_model[idx], w, s);
      end
      for (int i = 0; i < 6; i++) begin
         bus_access(soc_pkg::word_t'(slots[i] << 2), '0, '0, rd, ri);
         check_value("rdata_main", rd, main_model[slots[i]]);
      end

      // Boot word and its inverse in main at one index
      idx = int'($urandom % 1024);
      w = $urandom;
      bus_access(32'h4000_0000 | soc_pkg::word_t'(idx << 2), w, 4'hf, rd, ri);
      bus_access(soc_pkg::word_t'(idx << 2), ~w, 4'hf, rd, ri);
      main_model[idx] = ~w;
      iaddr = soc_pkg::word_t'(idx << 2);
      bus_access(32'h4000_0000 | soc_pkg::word_t'(idx << 2), '0, '0, rd, ri);
      check_value("rdata_boot", rd, w);
      check_value("rinstr_boot", ri, w);

      // Soft reset, fetch hand-over and core pulse
      check_value("mem_sel", soc_pkg::word_t'(mem_sel), 32'd0);
      bus_access(`SOC_CTRL_ADDR, 32'h1, 4'hf, rd, ri);
      check_value("mem_sel", soc_pkg::word_t'(mem_sel), 32'd1);
      core_reset_cycles(1'b0, n);
      check_value("core_resetn_delay", soc_pkg::word_t'(n), 32'd1);
      core_reset_cycles(1'b1, n);
      check_value("core_resetn_low", soc_pkg::word_t'(n), `SOC_CORE_RST_CYCLES);
      bus_access(soc_pkg::word_t'(idx << 2), '0, '0, rd, ri);
      check_value("rdata_main", rd, main_model[idx]);
      check_value("rinstr_main", ri, main_model[idx]);

      ////////////////////////////////////////////////////////////////////////////
      // UART divider, frame and busy flag
      ////////////////////////////////////////////////////////////////////////////

      d = 4 + int'($urandom % 9);
      bus_access(32'h8000_0000, soc_pkg::word_t'(d), 4'hf, rd, ri);
      bus_access(32'h8000_0000, '0, '0, rd, ri);
      check_value("uart_div", rd, soc_pkg::word_t'(d));
      tx_byte = 8'($urandom);
      bus_access(32'h8000_0004, {24'h0, tx_byte}, 4'h1, rd, ri);
      fork
         decode_frame(tx_byte, d);
         begin
            // Busy poll well inside the frame
            repeat (3 * d) @(negedge clk);
            bus_access(32'h8000_0004, '0, '0, rd, ri);
            check_value("uart_busy", rd, 32'd1);
         end
      join
      n = 0;
      do begin
         bus_access(32'h8000_0004, '0, '0, rd, ri);
         n++;
         if (n > 64) begin
            $display("Timeout waiting for the UART to go idle");
            halt_on_error();
         end
      end while (rd[0] !== 1'b0);
      check_value("uart_busy", rd, 32'd0);
      check_value("ser_tx_idle", soc_pkg::word_t'(ser_tx), 32'd1);

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/boot_control.sv
verilog/native_interconnect.sv
verilog/native_memory.sv
verilog/uart_tx.sv
verilog/soc_top.sv
verif/soc_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then decide on the log contents
rm -f sim.log
verilator --binary --timing --assert --top-module soc_tb -f compile.f -o soc_tb_sim \
   || { echo "Build failed"; exit 1; }
./obj_dir/soc_tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation ended without a verdict"; exit 1; }
